// File: common/video_pkg.sv
package video_pkg;

    // Pixel channel and coordinate widths.
    localparam int PIX_W = 8;
    localparam int X_W   = 11;
    localparam int Y_W   = 10;

    // White-balance gain, unsigned with GAIN_FRAC fraction bits.
    localparam int GAIN_W     = 10;
    localparam int GAIN_FRAC  = 8;
    localparam int GAIN_UNITY = 256;

    // Bits needed to hold one channel summed over a full frame.
    function automatic int sum_width(input int h_act, input int v_act);
        return $clog2(h_act * v_act * ((1 << PIX_W) - 1) + 1);
    endfunction

endpackage : video_pkg

// File: hw/cam_pixel_assembler.sv
module cam_pixel_assembler (
    input  logic                        clk,
    input  logic                        i_reset,
    input  logic                        i_cam_valid,
    input  logic                        i_cam_href,
    input  logic                        i_cam_vsync,
    input  logic [7:0]                  i_cam_data,
    output logic                        o_de,
    output logic                        o_vsync,
    output logic [video_pkg::X_W-1:0]   o_x,
    output logic [video_pkg::Y_W-1:0]   o_y,
    output logic [video_pkg::PIX_W-1:0] o_r,
    output logic [video_pkg::PIX_W-1:0] o_g,
    output logic [video_pkg::PIX_W-1:0] o_b
);
    import video_pkg::*;

    logic           href_d;
    logic           vsync_d;
    logic           pending;
    logic           line_has_pix;
    logic [7:0]     first_byte;
    logic [X_W-1:0] x_cnt;
    logic [Y_W-1:0] y_cnt;
    logic           href_rise;
    logic           href_fall;
    logic           vsync_rise;
    logic           byte_take;
    logic           pair_done;
    logic [4:0]     r5;
    logic [5:0]     g6;
    logic [4:0]     b5;

    assign href_rise  = i_cam_href & ~href_d;
    assign href_fall  = ~i_cam_href & href_d;
    assign vsync_rise = i_cam_vsync & ~vsync_d;
    assign byte_take  = i_cam_valid & i_cam_href;
    assign pair_done  = byte_take & pending;

    // First byte R5 G3, second byte G3 B5.
    assign r5 = first_byte[7:3];
    assign g6 = {first_byte[2:0], i_cam_data[7:5]};
    assign b5 = i_cam_data[4:0];

    // ~~~~~~~~~~~~~~~~~~~~
    // Byte pairing and coordinate counters.
    always_ff @(posedge clk) begin
        if (i_reset) begin
            href_d       <= 1'b0;
            vsync_d      <= 1'b0;
            pending      <= 1'b0;
            line_has_pix <= 1'b0;
            x_cnt        <= '0;
            y_cnt        <= '0;
            o_de         <= 1'b0;
            o_vsync      <= 1'b0;
        end else begin
            href_d  <= i_cam_href;
            vsync_d <= i_cam_vsync;
            o_de    <= pair_done;
            o_vsync <= vsync_rise;

            // An odd byte left at the end of a line is dropped.
            if (byte_take) begin
                pending <= ~pending;
            end else if (href_fall) begin
                pending <= 1'b0;
            end

            if (pair_done) begin
                x_cnt        <= x_cnt + 1'b1;
                line_has_pix <= 1'b1;
            end else if (href_rise) begin
                x_cnt <= '0;
            end else if (href_fall) begin
                line_has_pix <= 1'b0;
            end

            if (vsync_rise) begin
                y_cnt <= '0;
            end else if (href_fall && line_has_pix) begin
                y_cnt <= y_cnt + 1'b1;
            end
        end
    end

    // Expand to RGB888 by repeating the top bits.
    always_ff @(posedge clk) begin
        if (byte_take && !pending) begin
            first_byte <= i_cam_data;
        end
        if (pair_done) begin
            o_x <= x_cnt;
            o_y <= y_cnt;
            o_r <= {r5, r5[4:2]};
            o_g <= {g6, g6[5:4]};
            o_b <= {b5, b5[4:2]};
        end
    end

endmodule : cam_pixel_assembler

// File: white_balance/wb_frame_stats.sv
module wb_frame_stats #(
    parameter  int H_ACT = 1280,
    parameter  int V_ACT = 720,
    localparam int SUM_W = video_pkg::sum_width(H_ACT, V_ACT)
) (
    input  logic                        clk,
    input  logic                        i_reset,
    input  logic                        i_de,
    input  logic                        i_vsync,
    input  logic [video_pkg::PIX_W-1:0] i_r,
    input  logic [video_pkg::PIX_W-1:0] i_g,
    input  logic [video_pkg::PIX_W-1:0] i_b,
    output logic                        o_start,
    output logic [SUM_W-1:0]            o_sum_r,
    output logic [SUM_W-1:0]            o_sum_g,
    output logic [SUM_W-1:0]            o_sum_b
);

    logic [SUM_W-1:0] acc_r;
    logic [SUM_W-1:0] acc_g;
    logic [SUM_W-1:0] acc_b;
    logic             frame_has_pix;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            acc_r         <= '0;
            acc_g         <= '0;
            acc_b         <= '0;
            frame_has_pix <= 1'b0;
            o_start       <= 1'b0;
        end else begin
            // Empty frames give the divider nothing to do.
            o_start <= i_vsync & frame_has_pix;
            if (i_vsync) begin
                acc_r         <= '0;
                acc_g         <= '0;
                acc_b         <= '0;
                frame_has_pix <= 1'b0;
            end else if (i_de) begin
                acc_r         <= acc_r + i_r;
                acc_g         <= acc_g + i_g;
                acc_b         <= acc_b + i_b;
                frame_has_pix <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_vsync) begin
            o_sum_r <= acc_r;
            o_sum_g <= acc_g;
            o_sum_b <= acc_b;
        end
    end

endmodule : wb_frame_stats

// File: white_balance/wb_gain_divider.sv
module wb_gain_divider #(
    parameter int SUM_W = 28
) (
    input  logic                         clk,
    input  logic                         i_reset,
    input  logic                         i_start,
    input  logic [SUM_W-1:0]             i_sum_r,
    input  logic [SUM_W-1:0]             i_sum_g,
    input  logic [SUM_W-1:0]             i_sum_b,
    output logic                         o_done,
    output logic [video_pkg::GAIN_W-1:0] o_gain_r,
    output logic [video_pkg::GAIN_W-1:0] o_gain_b
);
    import video_pkg::*;

    localparam int DIV_W = SUM_W + GAIN_FRAC;
    localparam int CNT_W = $clog2(DIV_W);

    logic              busy;
    logic              second;
    logic              last_step;
    logic [CNT_W-1:0]  cnt;
    logic [SUM_W-1:0]  sum_g;
    logic [SUM_W-1:0]  sum_b;
    logic [SUM_W-1:0]  divisor;
    logic [SUM_W-1:0]  rem;
    logic [DIV_W-1:0]  quo;
    logic [SUM_W:0]    rem_shift;
    logic [SUM_W+1:0]  trial;
    logic              fits;
    logic [SUM_W-1:0]  rem_next;
    logic [DIV_W-1:0]  quo_next;
    logic [GAIN_W-1:0] gain;

    // ~~~~~~~~~~~~~~~~~~~~
    // One restoring step per cycle.
    assign rem_shift = {rem, quo[DIV_W-1]};
    assign trial     = {1'b0, rem_shift} - {2'b00, divisor};
    assign fits      = ~trial[SUM_W+1];
    assign rem_next  = fits ? trial[SUM_W-1:0] : rem_shift[SUM_W-1:0];
    assign quo_next  = {quo[DIV_W-2:0], fits};
    assign last_step = (cnt == CNT_W'(DIV_W - 1));

    // Saturate, and keep unity for a channel that summed to zero.
    always_comb begin
        if (divisor == '0) begin
            gain = GAIN_W'(GAIN_UNITY);
        end else if (quo_next > DIV_W'((1 << GAIN_W) - 1)) begin
            gain = '1;
        end else begin
            gain = quo_next[GAIN_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            busy   <= 1'b0;
            second <= 1'b0;
            cnt    <= '0;
            o_done <= 1'b0;
        end else begin
            o_done <= 1'b0;
            if (i_start) begin
                busy   <= 1'b1;
                second <= 1'b0;
                cnt    <= '0;
            end else if (busy) begin
                if (last_step) begin
                    cnt    <= '0;
                    second <= ~second;
                    if (second) begin
                        busy   <= 1'b0;
                        o_done <= 1'b1;
                    end
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

    // Red first, then blue, both over G*256.
    always_ff @(posedge clk) begin
        if (i_start) begin
            sum_g   <= i_sum_g;
            sum_b   <= i_sum_b;
            divisor <= i_sum_r;
            rem     <= '0;
            quo     <= {i_sum_g, {GAIN_FRAC{1'b0}}};
        end else if (busy) begin
            if (last_step) begin
                rem     <= '0;
                quo     <= {sum_g, {GAIN_FRAC{1'b0}}};
                divisor <= sum_b;
                if (second) begin
                    o_gain_b <= gain;
                end else begin
                    o_gain_r <= gain;
                end
            end else begin
                rem <= rem_next;
                quo <= quo_next;
            end
        end
    end

endmodule : wb_gain_divider

// File: white_balance/wb_gain_apply.sv
module wb_gain_apply #(
    parameter int H_ACT = 1280,
    parameter int V_ACT = 720
) (
    input  logic                        clk,
    input  logic                        i_reset,
    input  logic                        i_enable,
    input  logic                        i_de,
    input  logic                        i_vsync,
    input  logic [video_pkg::X_W-1:0]   i_x,
    input  logic [video_pkg::Y_W-1:0]   i_y,
    input  logic [video_pkg::PIX_W-1:0] i_r,
    input  logic [video_pkg::PIX_W-1:0] i_g,
    input  logic [video_pkg::PIX_W-1:0] i_b,
    output logic                        o_de,
    output logic                        o_vsync,
    output logic [video_pkg::X_W-1:0]   o_x,
    output logic [video_pkg::Y_W-1:0]   o_y,
    output logic [video_pkg::PIX_W-1:0] o_r,
    output logic [video_pkg::PIX_W-1:0] o_g,
    output logic [video_pkg::PIX_W-1:0] o_b
);
    import video_pkg::*;

    localparam int SUM_W = sum_width(H_ACT, V_ACT);

    logic              stats_start;
    logic [SUM_W-1:0]  sum_r;
    logic [SUM_W-1:0]  sum_g;
    logic [SUM_W-1:0]  sum_b;
    logic              gains_done;
    logic [GAIN_W-1:0] new_gain_r;
    logic [GAIN_W-1:0] new_gain_b;
    logic [GAIN_W-1:0] gain_r;
    logic [GAIN_W-1:0] gain_b;

    // (chan * gain) >> 8, clipped to full scale.
    function automatic logic [PIX_W-1:0] scale(input logic [PIX_W-1:0]  chan,
                                               input logic [GAIN_W-1:0] g);
        logic [PIX_W+GAIN_W-1:0] prod;
        prod = chan * g;
        if (|prod[PIX_W+GAIN_W-1:PIX_W+GAIN_FRAC]) begin
            return '1;
        end
        return prod[PIX_W+GAIN_FRAC-1:GAIN_FRAC];
    endfunction

    wb_frame_stats #(
        .H_ACT(H_ACT),
        .V_ACT(V_ACT)
    ) u_stats (
        .clk    (clk        ),
        .i_reset(i_reset    ),
        .i_de   (i_de       ),
        .i_vsync(i_vsync    ),
        .i_r    (i_r        ),
        .i_g    (i_g        ),
        .i_b    (i_b        ),
        .o_start(stats_start),
        .o_sum_r(sum_r      ),
        .o_sum_g(sum_g      ),
        .o_sum_b(sum_b      )
    );

    wb_gain_divider #(.SUM_W(SUM_W)) u_divider (
        .clk     (clk        ),
        .i_reset (i_reset    ),
        .i_start (stats_start),
        .i_sum_r (sum_r      ),
        .i_sum_g (sum_g      ),
        .i_sum_b (sum_b      ),
        .o_done  (gains_done ),
        .o_gain_r(new_gain_r ),
        .o_gain_b(new_gain_b )
    );

    always_ff @(posedge clk) begin
        if (i_reset) begin
            gain_r  <= GAIN_W'(GAIN_UNITY);
            gain_b  <= GAIN_W'(GAIN_UNITY);
            o_de    <= 1'b0;
            o_vsync <= 1'b0;
        end else begin
            o_de    <= i_de;
            o_vsync <= i_vsync;
            if (gains_done) begin
                gain_r <= new_gain_r;
                gain_b <= new_gain_b;
            end
        end
    end

    always_ff @(posedge clk) begin
        o_x <= i_x;
        o_y <= i_y;
        o_g <= i_g;
        o_r <= i_enable ? scale(i_r, gain_r) : i_r;
        o_b <= i_enable ? scale(i_b, gain_b) : i_b;
    end

endmodule : wb_gain_apply

// File: hw/draw_window.sv
module draw_window #(
    parameter int          WIN_X0     = 100,
    parameter int          WIN_Y0     = 200,
    parameter int          WIN_X1     = 200,
    parameter int          WIN_Y1     = 400,
    parameter int          WIN_BORDER = 4,
    parameter logic [23:0] WIN_COLOR  = 24'hFFFFFF
) (
    input  logic                        clk,
    input  logic                        i_reset,
    input  logic                        i_enable,
    input  logic                        i_de,
    input  logic                        i_vsync,
    input  logic [video_pkg::X_W-1:0]   i_x,
    input  logic [video_pkg::Y_W-1:0]   i_y,
    input  logic [video_pkg::PIX_W-1:0] i_r,
    input  logic [video_pkg::PIX_W-1:0] i_g,
    input  logic [video_pkg::PIX_W-1:0] i_b,
    output logic                        o_de,
    output logic                        o_vsync,
    output logic [video_pkg::X_W-1:0]   o_x,
    output logic [video_pkg::Y_W-1:0]   o_y,
    output logic [video_pkg::PIX_W-1:0] o_r,
    output logic [video_pkg::PIX_W-1:0] o_g,
    output logic [video_pkg::PIX_W-1:0] o_b
);

    logic in_outer;
    logic in_inner;
    logic paint;

    // Border is the outer rectangle minus the inner one.
    assign in_outer = (int'(i_x) >= WIN_X0) && (int'(i_x) <= WIN_X1) &&
                      (int'(i_y) >= WIN_Y0) && (int'(i_y) <= WIN_Y1);
    assign in_inner = (int'(i_x) >= WIN_X0 + WIN_BORDER) &&
                      (int'(i_x) <= WIN_X1 - WIN_BORDER) &&
                      (int'(i_y) >= WIN_Y0 + WIN_BORDER) &&
                      (int'(i_y) <= WIN_Y1 - WIN_BORDER);
    assign paint    = i_enable & in_outer & ~in_inner;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_de    <= 1'b0;
            o_vsync <= 1'b0;
        end else begin
            o_de    <= i_de;
            o_vsync <= i_vsync;
        end
    end

    always_ff @(posedge clk) begin
        o_x <= i_x;
        o_y <= i_y;
        o_r <= paint ? WIN_COLOR[23:16] : i_r;
        o_g <= paint ? WIN_COLOR[15:8]  : i_g;
        o_b <= paint ? WIN_COLOR[7:0]   : i_b;
    end

endmodule : draw_window

// File: hw/video_pipe_top.sv
module video_pipe_top #(
    parameter int          H_ACT      = 1280,
    parameter int          V_ACT      = 720,
    parameter int          WIN_X0     = 100,
    parameter int          WIN_Y0     = 200,
    parameter int          WIN_X1     = 200,
    parameter int          WIN_Y1     = 400,
    parameter int          WIN_BORDER = 4,
    parameter logic [23:0] WIN_COLOR  = 24'hFFFFFF
) (
    input  logic                        clk,
    input  logic                        i_reset,
    input  logic                        i_cam_valid,
    input  logic                        i_cam_href,
    input  logic                        i_cam_vsync,
    input  logic [7:0]                  i_cam_data,
    input  logic                        i_wb_enable,
    input  logic                        i_dw_enable,
    output logic                        o_de,
    output logic                        o_vsync,
    output logic [video_pkg::X_W-1:0]   o_x,
    output logic [video_pkg::Y_W-1:0]   o_y,
    output logic [video_pkg::PIX_W-1:0] o_r,
    output logic [video_pkg::PIX_W-1:0] o_g,
    output logic [video_pkg::PIX_W-1:0] o_b
);
    import video_pkg::*;

    // ~~~~~~~~~~~~~~~~~~~~
    // Camera stage to white balance.
    logic             cam_de;
    logic             cam_vsync;
    logic [X_W-1:0]   cam_x;
    logic [Y_W-1:0]   cam_y;
    logic [PIX_W-1:0] cam_r;
    logic [PIX_W-1:0] cam_g;
    logic [PIX_W-1:0] cam_b;

    // White balance to overlay.
    logic             wb_de;
    logic             wb_vsync;
    logic [X_W-1:0]   wb_x;
    logic [Y_W-1:0]   wb_y;
    logic [PIX_W-1:0] wb_r;
    logic [PIX_W-1:0] wb_g;
    logic [PIX_W-1:0] wb_b;

    cam_pixel_assembler u_cam_assembler (
        .clk        (clk        ),
        .i_reset    (i_reset    ),
        .i_cam_valid(i_cam_valid),
        .i_cam_href (i_cam_href ),
        .i_cam_vsync(i_cam_vsync),
        .i_cam_data (i_cam_data ),
        .o_de       (cam_de     ),
        .o_vsync    (cam_vsync  ),
        .o_x        (cam_x      ),
        .o_y        (cam_y      ),
        .o_r        (cam_r      ),
        .o_g        (cam_g      ),
        .o_b        (cam_b      )
    );

    wb_gain_apply #(
        .H_ACT(H_ACT),
        .V_ACT(V_ACT)
    ) u_white_balance (
        .clk     (clk        ),
        .i_reset (i_reset    ),
        .i_enable(i_wb_enable),
        .i_de    (cam_de     ),
        .i_vsync (cam_vsync  ),
        .i_x     (cam_x      ),
        .i_y     (cam_y      ),
        .i_r     (cam_r      ),
        .i_g     (cam_g      ),
        .i_b     (cam_b      ),
        .o_de    (wb_de      ),
        .o_vsync (wb_vsync   ),
        .o_x     (wb_x       ),
        .o_y     (wb_y       ),
        .o_r     (wb_r       ),
        .o_g     (wb_g       ),
        .o_b     (wb_b       )
    );

    draw_window #(
        .WIN_X0    (WIN_X0    ),
        .WIN_Y0    (WIN_Y0    ),
        .WIN_X1    (WIN_X1    ),
        .WIN_Y1    (WIN_Y1    ),
        .WIN_BORDER(WIN_BORDER),
        .WIN_COLOR (WIN_COLOR )
    ) u_draw_window (
        .clk     (clk        ),
        .i_reset (i_reset    ),
        .i_enable(i_dw_enable),
        .i_de    (wb_de      ),
        .i_vsync (wb_vsync   ),
        .i_x     (wb_x       ),
        .i_y     (wb_y       ),
        .i_r     (wb_r       ),
        .i_g     (wb_g       ),
        .i_b     (wb_b       ),
        .o_de    (o_de       ),
        .o_vsync (o_vsync    ),
        .o_x     (o_x        ),
        .o_y     (o_y        ),
        .o_r     (o_r        ),
        .o_g     (o_g        ),
        .o_b     (o_b        )
    );

endmodule : video_pipe_top

// File: testbench/video_pipe_checker.sv
module video_pipe_checker #(
    parameter int H_ACT = 1280
) (
    input logic                      clk,
    input logic                      i_reset,
    input logic                      i_de,
    input logic                      i_vsync,
    input logic [video_pkg::X_W-1:0] i_x
);

    int unsigned assert_errors = 0;

    a_de_low_in_reset: assert property (@(posedge clk) i_reset |=> !i_de)
        else begin
            $error("o_de high while reset is applied");
            assert_errors++;
        end

    a_vsync_not_with_de: assert property (@(posedge clk) disable iff (i_reset)
        !(i_vsync && i_de))
        else begin
            $error("o_vsync and o_de high in the same cycle");
            assert_errors++;
        end

    a_x_in_range: assert property (@(posedge clk) disable iff (i_reset)
        i_de |-> (int'(i_x) < H_ACT))
        else begin
            $error("o_x beyond the active line width");
            assert_errors++;
        end

endmodule : video_pipe_checker

// File: testbench/video_pipe_monitor.sv
module video_pipe_monitor (
    input logic                        clk,
    input logic                        i_de,
    input logic                        i_vsync,
    input logic [video_pkg::X_W-1:0]   i_x,
    input logic [video_pkg::Y_W-1:0]   i_y,
    input logic [video_pkg::PIX_W-1:0] i_r,
    input logic [video_pkg::PIX_W-1:0] i_g,
    input logic [video_pkg::PIX_W-1:0] i_b
);
    import video_pkg::*;

    // Cycles from a camera event to the matching output.
    localparam int LATENCY = 3;
    localparam int ENTRY_W = X_W + Y_W + 3 * PIX_W;

    int unsigned        cycle = 0;
    int unsigned        errors = 0;
    logic [ENTRY_W-1:0] pix_q[$];
    int unsigned        pix_cause_q[$];
    int unsigned        vsync_cause_q[$];

    task automatic expect_pixel(input logic [X_W-1:0] x, input logic [Y_W-1:0] y,
                                input logic [3*PIX_W-1:0] rgb, input int unsigned cause);
        pix_q.push_back({x, y, rgb});
        pix_cause_q.push_back(cause);
    endtask

    task automatic expect_vsync(input int unsigned cause);
        vsync_cause_q.push_back(cause);
    endtask

    function automatic int pending();
        return pix_q.size() + vsync_cause_q.size();
    endfunction

    function automatic void flush();
        pix_q.delete();
        pix_cause_q.delete();
        vsync_cause_q.delete();
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    always @(posedge clk) begin : compare
        logic [ENTRY_W-1:0] got;
        logic [ENTRY_W-1:0] exp_pix;
        int unsigned        cause;
        cycle = cycle + 1;
        got = {i_x, i_y, i_r, i_g, i_b};
        if (i_de === 1'b1) begin
            if (pix_q.size() == 0) begin
                $display("Unexpected pixel at time %0t: o_de high with nothing expected", $time);
                errors++;
            end else begin
                exp_pix = pix_q.pop_front();
                cause   = pix_cause_q.pop_front();
                if (got !== exp_pix) begin
                    $display("Mismatch at time %0t: pixel (%0d,%0d) rgb %h, expected (%0d,%0d) rgb %h",
                             $time, i_x, i_y, got[3*PIX_W-1:0], exp_pix[ENTRY_W-1 -: X_W],
                             exp_pix[3*PIX_W +: Y_W], exp_pix[3*PIX_W-1:0]);
                    errors++;
                end
                if (cycle != cause + LATENCY) begin
                    $display("Mismatch at time %0t: o_de %0d cycles after its byte pair",
                             $time, cycle - cause);
                    errors++;
                end
            end
        end
        if (i_vsync === 1'b1) begin
            if (vsync_cause_q.size() == 0) begin
                $display("Unexpected vsync at time %0t: no camera vsync rise before it", $time);
                errors++;
            end else begin
                cause = vsync_cause_q.pop_front();
                if (cycle != cause + LATENCY) begin
                    $display("Mismatch at time %0t: o_vsync %0d cycles after the vsync rise",
                             $time, cycle - cause);
                    errors++;
                end
            end
        end
    end

endmodule : video_pipe_monitor

// File: testbench/video_pipe_tb.sv
module video_pipe_tb;
    import video_pkg::*;

    localparam int          H_ACT      = 16;
    localparam int          V_ACT      = 8;
    localparam int          WIN_X0     = 3;
    localparam int          WIN_Y0     = 2;
    localparam int          WIN_X1     = 12;
    localparam int          WIN_Y1     = 6;
    localparam int          WIN_BORDER = 1;
    localparam logic [23:0] WIN_COLOR  = 24'hFF00FF;

    localparam int BLANK         = 200;
    localparam int DRAIN_CYCLES  = 20;
    localparam int NUM_FRAMES    = 13;
    localparam int LINE_BUDGET   = H_ACT * 2 * 3 + 20;
    localparam int WATCHDOG_TIME = NUM_FRAMES * (LINE_BUDGET * V_ACT + BLANK) * 4 * 2;

    // Limits on the red field of each first byte.
    localparam int RED_FULL = 0;
    localparam int RED_DIM  = 1;
    localparam int RED_ZERO = 2;

    logic             clk = 1'b0;
    logic             reset;
    logic             cam_valid;
    logic             cam_href;
    logic             cam_vsync;
    logic [7:0]       cam_data;
    logic             wb_enable;
    logic             dw_enable;
    logic             out_de;
    logic             out_vsync;
    logic [X_W-1:0]   out_x;
    logic [Y_W-1:0]   out_y;
    logic [PIX_W-1:0] out_r;
    logic [PIX_W-1:0] out_g;
    logic [PIX_W-1:0] out_b;

    // Reference model state.
    int gain_r;
    int gain_b;
    int sum_r;
    int sum_g;
    int sum_b;
    int frame_pixels;
    int line_y;
    int tests_run;
    int tests_failed;
    int tb_errors;
    int errors_at_test_start;

    always #2 clk = ~clk;

    video_pipe_top #(
        .H_ACT     (H_ACT     ),
        .V_ACT     (V_ACT     ),
        .WIN_X0    (WIN_X0    ),
        .WIN_Y0    (WIN_Y0    ),
        .WIN_X1    (WIN_X1    ),
        .WIN_Y1    (WIN_Y1    ),
        .WIN_BORDER(WIN_BORDER),
        .WIN_COLOR (WIN_COLOR )
    ) i_video_pipe_top (
        .clk        (clk      ),
        .i_reset    (reset    ),
        .i_cam_valid(cam_valid),
        .i_cam_href (cam_href ),
        .i_cam_vsync(cam_vsync),
        .i_cam_data (cam_data ),
        .i_wb_enable(wb_enable),
        .i_dw_enable(dw_enable),
        .o_de       (out_de   ),
        .o_vsync    (out_vsync),
        .o_x        (out_x    ),
        .o_y        (out_y    ),
        .o_r        (out_r    ),
        .o_g        (out_g    ),
        .o_b        (out_b    )
    );

    video_pipe_monitor u_monitor (
        .clk    (clk      ),
        .i_de   (out_de   ),
        .i_vsync(out_vsync),
        .i_x    (out_x    ),
        .i_y    (out_y    ),
        .i_r    (out_r    ),
        .i_g    (out_g    ),
        .i_b    (out_b    )
    );

    bind video_pipe_top video_pipe_checker #(.H_ACT(H_ACT)) u_checker (
        .clk    (clk    ),
        .i_reset(i_reset),
        .i_de   (o_de   ),
        .i_vsync(o_vsync),
        .i_x    (o_x    )
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // Reference model.
    function automatic logic [23:0] expand_pair(input logic [7:0] first, input logic [7:0] second);
        int r5;
        int g6;
        int b5;
        r5 = first >> 3;
        g6 = ((first & 8'h07) << 3) | (second >> 5);
        b5 = second & 8'h1F;
        return {8'((r5 << 3) | (r5 >> 2)), 8'((g6 << 2) | (g6 >> 4)), 8'((b5 << 3) | (b5 >> 2))};
    endfunction

    function automatic int gain_from_sums(input int num, input int den);
        longint q;
        if (den == 0) begin
            return GAIN_UNITY;
        end
        q = (longint'(num) * 256) / den;
        return (q > (1 << GAIN_W) - 1) ? (1 << GAIN_W) - 1 : int'(q);
    endfunction

    function automatic int apply_gain(input int chan, input int gain);
        int v;
        v = (chan * gain) / 256;
        return (v > 255) ? 255 : v;
    endfunction

    function automatic bit on_border(input int x, input int y);
        bit in_rect;
        in_rect = x >= WIN_X0 && x <= WIN_X1 && y >= WIN_Y0 && y <= WIN_Y1;
        return in_rect && (x - WIN_X0 < WIN_BORDER || WIN_X1 - x < WIN_BORDER ||
                           y - WIN_Y0 < WIN_BORDER || WIN_Y1 - y < WIN_BORDER);
    endfunction

    function automatic logic [23:0] reference_pixel(input logic [23:0] rgb, input int x,
                                                    input int y);
        int r;
        int g;
        int b;
        r = rgb[23:16];
        g = rgb[15:8];
        b = rgb[7:0];
        if (wb_enable) begin
            r = apply_gain(r, gain_r);
            b = apply_gain(b, gain_b);
        end
        if (dw_enable && on_border(x, y)) begin
            return WIN_COLOR;
        end
        return {8'(r), 8'(g), 8'(b)};
    endfunction

    function automatic int error_total();
        return u_monitor.errors + i_video_pipe_top.u_checker.assert_errors + tb_errors;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    // Stimulus.
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic reset_dut();
        reset     = 1'b1;
        cam_valid = 1'b0;
        cam_href  = 1'b0;
        cam_vsync = 1'b0;
        cam_data  = '0;
        repeat (5) next_cycle();
        reset        = 1'b0;
        gain_r       = GAIN_UNITY;
        gain_b       = GAIN_UNITY;
        sum_r        = 0;
        sum_g        = 0;
        sum_b        = 0;
        frame_pixels = 0;
        line_y       = 0;
    endtask

    // The closing frame's sums become the gains of the next one.
    task automatic start_frame();
        cam_vsync = 1'b1;
        u_monitor.expect_vsync(u_monitor.cycle + 1);
        next_cycle();
        cam_vsync = 1'b0;
        if (frame_pixels > 0) begin
            gain_r = gain_from_sums(sum_g, sum_r);
            gain_b = gain_from_sums(sum_g, sum_b);
        end
        sum_r        = 0;
        sum_g        = 0;
        sum_b        = 0;
        frame_pixels = 0;
        line_y       = 0;
        repeat (BLANK) next_cycle();
    endtask

    task automatic send_byte(input logic [7:0] data, output int unsigned cause);
        if ($urandom_range(0, 1) == 1) begin
            cam_valid = 1'b0;
            next_cycle();
        end
        cam_valid = 1'b1;
        cam_data  = data;
        cause     = u_monitor.cycle + 1;
        next_cycle();
        cam_valid = 1'b0;
    endtask

    task automatic send_line(input int n_bytes, input int mode);
        logic [7:0]  first;
        logic [7:0]  data;
        logic [23:0] rgb;
        int          x;
        int unsigned cause;
        x     = 0;
        first = '0;
        cam_href = 1'b1;
        next_cycle();
        for (int i = 0; i < n_bytes; i++) begin
            data = 8'($urandom);
            if (i % 2 == 0) begin
                if (mode == RED_DIM) begin
                    data = data & 8'h3F;
                end else if (mode == RED_ZERO) begin
                    data = data & 8'h07;
                end
                first = data;
            end
            send_byte(data, cause);
            if (i % 2 == 1) begin
                rgb = expand_pair(first, data);
                sum_r += rgb[23:16];
                sum_g += rgb[15:8];
                sum_b += rgb[7:0];
                frame_pixels++;
                u_monitor.expect_pixel(X_W'(x), Y_W'(line_y), reference_pixel(rgb, x, line_y),
                                       cause);
                x++;
            end
        end
        cam_href = 1'b0;
        repeat (4) next_cycle();
        if (x > 0) begin
            line_y++;
        end
    endtask

    task automatic send_frame(input int n_lines, input int mode);
        start_frame();
        repeat (n_lines) send_line(2 * H_ACT, mode);
    endtask

    task automatic finish_test(input string name);
        int waited;
        int errs;
        waited = 0;
        while (u_monitor.pending() > 0 && waited < DRAIN_CYCLES) begin
            next_cycle();
            waited++;
        end
        if (u_monitor.pending() > 0) begin
            $display("Test %s: %0d expected outputs never appeared", name, u_monitor.pending());
            u_monitor.flush();
            tb_errors++;
        end
        errs = error_total();
        tests_run++;
        if (errs != errors_at_test_start) begin
            tests_failed++;
        end
        $display("test %0d %s: %s", tests_run, name,
                 (errs == errors_at_test_start) ? "ok" : "FAILED");
        errors_at_test_start = errs;
    endtask

    initial begin
        #(WATCHDOG_TIME);
        $display("Timeout: the tests did not finish in %0d time units", WATCHDOG_TIME);
        $display("sim failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h69b5_b2bf));
        wb_enable            = 1'b0;
        dw_enable            = 1'b0;
        tests_run            = 0;
        tests_failed         = 0;
        tb_errors            = 0;
        errors_at_test_start = 0;
        reset_dut();

        send_frame(V_ACT, RED_FULL);
        send_frame(V_ACT, RED_FULL);
        finish_test("bypass");

        reset_dut();
        wb_enable = 1'b1;
        send_frame(V_ACT, RED_FULL);
        finish_test("wb unity after reset");

        // A dim red frame drives the red gain into saturation.
        send_frame(V_ACT, RED_FULL);
        send_frame(V_ACT, RED_DIM);
        send_frame(V_ACT, RED_FULL);
        send_frame(V_ACT, RED_ZERO);
        send_frame(V_ACT, RED_FULL);
        finish_test("wb gains");

        wb_enable = 1'b0;
        dw_enable = 1'b1;
        send_frame(V_ACT, RED_FULL);
        wb_enable = 1'b1;
        send_frame(V_ACT, RED_FULL);
        finish_test("overlay");

        wb_enable = 1'b0;
        dw_enable = 1'b0;
        start_frame();
        send_line(2 * 9 + 1, RED_FULL);
        send_line(1, RED_FULL);
        send_line(2 * H_ACT, RED_FULL);
        finish_test("odd byte");

        start_frame();
        repeat (3) send_line(2 * H_ACT, RED_FULL);
        start_frame();
        repeat (2) send_line(2 * H_ACT, RED_FULL);
        finish_test("vsync restart");

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
                 error_total());
        if (error_total() == 0 && tests_failed == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule : video_pipe_tb

// File: vlog.f
common/video_pkg.sv
hw/cam_pixel_assembler.sv
white_balance/wb_frame_stats.sv
white_balance/wb_gain_divider.sv
white_balance/wb_gain_apply.sv
hw/draw_window.sv
hw/video_pipe_top.sv
testbench/video_pipe_checker.sv
testbench/video_pipe_monitor.sv
testbench/video_pipe_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f vlog.f \
        --top-module video_pipe_tb -o sim_video_pipe; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_video_pipe +verilator+error+limit+1000)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "sim passed"; then
    exit 0
fi
exit 1
